/* project.f */
+incdir+rtl
rtl/h_pkg.sv
rtl/wh_pkg.sv
rtl/weight_bank.sv
rtl/sp_pe.sv
rtl/wh_row_packer.sv
rtl/spmm_core.sv
test/tb_spmm_core.sv

/* rtl/h_pkg.sv */
`default_nettype none

`include "spmm_params.svh"

// Sparse input side of the stage
package h_pkg;

  // Column index of one nonzero entry in H
  typedef logic [$clog2(`SPMM_NUM_FEATURE_IN)-1:0] col_idx_t;

  // Nonzeros per row with one extra bit so a full row fits
  typedef logic [$clog2(`SPMM_NUM_FEATURE_IN):0] row_len_t;

  // Node count sent along with each row
  typedef logic [$clog2(`SPMM_MAX_NODES)-1:0] num_node_t;

endpackage

`default_nettype wire

/* rtl/sp_pe.sv */
`timescale 1ns/10ps
`default_nettype none

module sp_pe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               spmm_vld_i,
  input  logic               pe_vld_i,
  input  h_pkg::col_idx_t    col_idx_i,
  input  h_pkg::row_len_t    row_len_i,
  input  h_pkg::num_node_t   num_node_i,
  input  logic               src_flag_i,
  output h_pkg::col_idx_t    wgt_addr_o,
  input  wh_pkg::wgt_t       wgt_dout_i,
  output logic               row_rdy_o,
  output logic               res_vld_o,
  output wh_pkg::wh_elem_t   res_o,
  output h_pkg::num_node_t   num_node_o,
  output logic               src_flag_o
);

  import h_pkg::*;
  import wh_pkg::*;

  // Entry pipeline
  // Stage 1 lines up with the bank read and stage 2 with its data
  col_idx_t   col_q;
  logic       vld_q1;
  logic       vld_q2;
  row_len_t   len_q1;
  row_len_t   len_q2;
  logic       first_q1;
  logic       first_q2;

  // Accumulate stage
  row_len_t   cnt;
  row_len_t   cnt_nxt;
  logic       last;
  wh_elem_t   wgt_ext;
  wh_elem_t   acc;
  logic       res_vld_q;

  // Node info delay line
  num_node_t  node_q1;
  num_node_t  node_q2;
  num_node_t  node_q3;
  logic       flag_q1;
  logic       flag_q2;
  logic       flag_q3;

  // Address only moves with an entry so the bank read stays put while idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q  <= '0;
      vld_q1 <= 1'b0;
      vld_q2 <= 1'b0;
    end else begin
      vld_q1 <= spmm_vld_i;
      vld_q2 <= vld_q1;
      if (spmm_vld_i) begin
        col_q <= col_idx_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    len_q1   <= row_len_i;
    len_q2   <= len_q1;
    first_q1 <= pe_vld_i;
    first_q2 <= first_q1;
  end

  assign wgt_addr_o = col_q;

  // Entry count including the one now in stage 2
  assign cnt_nxt = first_q2 ? row_len_t'(1) : cnt + row_len_t'(1);
  assign last    = (cnt_nxt == len_q2);

  // Weights are sign extended before the wrapping add
  assign wgt_ext = wh_elem_t'(wgt_dout_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      res_vld_q <= 1'b0;
    end else begin
      res_vld_q <= vld_q2 && last;
      if (vld_q2) begin
        cnt <= last ? '0 : cnt_nxt;
      end
    end
  end

  // First entry restarts the sum
  always_ff @(posedge clk) begin
    if (vld_q2) begin
      acc <= first_q2 ? wgt_ext : acc + wgt_ext;
    end
  end

  // Three stages so node info leaves together with res_vld_o
  always_ff @(posedge clk) begin
    if (pe_vld_i) begin
      node_q1 <= num_node_i;
      flag_q1 <= src_flag_i;
    end
    node_q2 <= node_q1;
    node_q3 <= node_q2;
    flag_q2 <= flag_q1;
    flag_q3 <= flag_q2;
  end

  assign row_rdy_o  = (cnt == '0);
  assign res_vld_o  = res_vld_q;
  assign res_o      = acc;
  assign num_node_o = node_q3;
  assign src_flag_o = flag_q3;

  // Empty rows never reach the PE
  a_row_len_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    spmm_vld_i |-> (row_len_i != '0)
  ) else $error("sp_pe: entry with zero row length");

  // A row starts on a strobe at a row boundary or behind entries still in flight
  a_row_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    pe_vld_i |-> (spmm_vld_i && (row_rdy_o || vld_q1 || vld_q2))
  ) else $error("sp_pe: pe_vld_i outside a row boundary or without spmm_vld_i");

endmodule

`default_nettype wire

/* rtl/spmm_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spmm_params.svh"

module spmm_core (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      spmm_vld_i,
  input  logic                                      pe_vld_i,
  input  h_pkg::col_idx_t                           col_idx_i,
  input  h_pkg::row_len_t                           row_len_i,
  input  h_pkg::num_node_t                          num_node_i,
  input  logic                                      src_flag_i,
  input  logic                                      wgt_we_i,
  input  logic [$clog2(`SPMM_NUM_FEATURE_OUT)-1:0]  wgt_col_i,
  input  h_pkg::col_idx_t                           wgt_addr_i,
  input  wh_pkg::wgt_t                              wgt_data_i,
  output logic                                      row_rdy_o,
  output logic                                      wh_vld_o,
  output wh_pkg::wh_row_t                           wh_row_o,
  output h_pkg::num_node_t                          num_node_o,
  output logic                                      src_flag_o
);

  import h_pkg::*;
  import wh_pkg::*;

  logic [`SPMM_NUM_FEATURE_OUT-1:0]  bank_we;
  col_idx_t                          bank_raddr [`SPMM_NUM_FEATURE_OUT];
  wgt_t                              bank_rdata [`SPMM_NUM_FEATURE_OUT];
  logic [`SPMM_NUM_FEATURE_OUT-1:0]  res_vld;
  wh_row_t                           res_row;
  num_node_t                         row_num_node;
  logic                              row_src_flag;

  // Weight load goes to one bank only
  always_comb begin
    bank_we            = '0;
    bank_we[wgt_col_i] = wgt_we_i;
  end

  for (genvar j = 0; j < `SPMM_NUM_FEATURE_OUT; j++) begin : g_feat
    weight_bank #(
      .DEPTH (`SPMM_NUM_FEATURE_IN)
    ) u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (bank_we[j]),
      .waddr_i (wgt_addr_i),
      .wdata_i (wgt_data_i),
      .raddr_i (bank_raddr[j]),
      .rdata_o (bank_rdata[j])
    );

    // PE 0 also reports row readiness and node info
    if (j == 0) begin : g_lead
      sp_pe u_pe (
        .clk        (clk),
        .rst_n      (rst_n),
        .spmm_vld_i (spmm_vld_i),
        .pe_vld_i   (pe_vld_i),
        .col_idx_i  (col_idx_i),
        .row_len_i  (row_len_i),
        .num_node_i (num_node_i),
        .src_flag_i (src_flag_i),
        .wgt_addr_o (bank_raddr[j]),
        .wgt_dout_i (bank_rdata[j]),
        .row_rdy_o  (row_rdy_o),
        .res_vld_o  (res_vld[j]),
        .res_o      (res_row[j]),
        .num_node_o (row_num_node),
        .src_flag_o (row_src_flag)
      );
    end else begin : g_follow
      sp_pe u_pe (
        .clk        (clk),
        .rst_n      (rst_n),
        .spmm_vld_i (spmm_vld_i),
        .pe_vld_i   (pe_vld_i),
        .col_idx_i  (col_idx_i),
        .row_len_i  (row_len_i),
        .num_node_i (num_node_i),
        .src_flag_i (src_flag_i),
        .wgt_addr_o (bank_raddr[j]),
        .wgt_dout_i (bank_rdata[j]),
        .row_rdy_o  (),
        .res_vld_o  (res_vld[j]),
        .res_o      (res_row[j]),
        .num_node_o (),
        .src_flag_o ()
      );
    end
  end

  wh_row_packer u_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_vld_i  (res_vld),
    .res_i      (res_row),
    .num_node_i (row_num_node),
    .src_flag_i (row_src_flag),
    .wh_vld_o   (wh_vld_o),
    .wh_row_o   (wh_row_o),
    .num_node_o (num_node_o),
    .src_flag_o (src_flag_o)
  );

endmodule

`default_nettype wire

/* rtl/spmm_params.svh */
`ifndef SPMM_PARAMS_SVH
`define SPMM_PARAMS_SVH

// Columns of H and rows of W
`define SPMM_NUM_FEATURE_IN 64

// Output features with one PE and one weight bank each
`define SPMM_NUM_FEATURE_OUT 4

// Signed weight word
`define SPMM_DATA_WIDTH 8

// Accumulator width where sums wrap
`define SPMM_WH_DATA_WIDTH 12

// Largest node count of a subgraph
`define SPMM_MAX_NODES 16

`endif

/* rtl/weight_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spmm_params.svh"

module weight_bank #(
  parameter int DEPTH = `SPMM_NUM_FEATURE_IN
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             we_i,
  input  h_pkg::col_idx_t  waddr_i,
  input  wh_pkg::wgt_t     wdata_i,
  input  h_pkg::col_idx_t  raddr_i,
  output wh_pkg::wgt_t     rdata_o
);

  import wh_pkg::*;

  // One column of W
  wgt_t mem [DEPTH];

  // Simple dual port with a registered read that maps onto block RAM
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];
  end

  // A freshly issued read must not hit the word being written
  a_no_collision: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we_i && $changed(raddr_i)) |-> (waddr_i != raddr_i)
  ) else $error("weight_bank: write and read collide at address %0d", waddr_i);

endmodule

`default_nettype wire

/* rtl/wh_pkg.sv */
`default_nettype none

`include "spmm_params.svh"

// Weight and result side of the stage
package wh_pkg;

  typedef logic signed [`SPMM_DATA_WIDTH-1:0] wgt_t;

  // Running sum of one output feature
  typedef logic signed [`SPMM_WH_DATA_WIDTH-1:0] wh_elem_t;

  // Element j holds output feature j
  typedef wh_elem_t [`SPMM_NUM_FEATURE_OUT-1:0] wh_row_t;

endpackage

`default_nettype wire

/* rtl/wh_row_packer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spmm_params.svh"

module wh_row_packer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [`SPMM_NUM_FEATURE_OUT-1:0]  res_vld_i,
  input  wh_pkg::wh_row_t                   res_i,
  input  h_pkg::num_node_t                  num_node_i,
  input  logic                              src_flag_i,
  output logic                              wh_vld_o,
  output wh_pkg::wh_row_t                   wh_row_o,
  output h_pkg::num_node_t                  num_node_o,
  output logic                              src_flag_o
);

  // One strobe per finished row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= res_vld_i[0];
    end
  end

  // Row held until the next one ends
  always_ff @(posedge clk) begin
    if (res_vld_i[0]) begin
      wh_row_o   <= res_i;
      num_node_o <= num_node_i;
      src_flag_o <= src_flag_i;
    end
  end

  // PE 0 speaks for all PEs so they must finish together
  a_pe_lockstep: assert property (
    @(posedge clk) disable iff (!rst_n)
    (res_vld_i == '0) || (res_vld_i == '1)
  ) else $error("wh_row_packer: PE valids disagree %b", res_vld_i);

endmodule

`default_nettype wire

/* test/tb_spmm_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spmm_params.svh"

module tb_spmm_core;

  import h_pkg::*;
  import wh_pkg::*;

  localparam int FEAT_IN     = `SPMM_NUM_FEATURE_IN;
  localparam int FEAT_OUT    = `SPMM_NUM_FEATURE_OUT;
  localparam int DATA_W      = `SPMM_DATA_WIDTH;
  localparam int WH_W        = `SPMM_WH_DATA_WIDTH;
  localparam int COL_W       = $clog2(FEAT_OUT);
  localparam int N_SINGLE    = 16;
  localparam int N_B2B       = 24;
  localparam int N_GAP       = 16;
  localparam int N_WRAP      = 12;
  localparam int MAX_LEN     = 8;
  localparam int MAX_GAP     = 3;
  localparam int WRAP_LEN    = 40;
  localparam int MAX_ROWS    = 128;
  localparam int DRAIN_LIMIT = 20;
  // Worst case entry cycles with one idle cycle between wrap row entries
  localparam int MAX_ENTRIES = N_SINGLE + N_B2B * MAX_LEN
                             + N_GAP * MAX_LEN * (MAX_GAP + 1) + N_WRAP * WRAP_LEN * 2;
  localparam int RUN_CYCLES  = 10 + 2 * FEAT_IN * FEAT_OUT + MAX_ENTRIES + 6 * DRAIN_LIMIT;
  localparam int WATCHDOG_NS = RUN_CYCLES * 4 + 1000;

  logic clk = 1'b0;
  logic rst_n;
  logic spmm_vld_i, pe_vld_i, src_flag_i, wgt_we_i;
  col_idx_t col_idx_i, wgt_addr_i;
  row_len_t row_len_i;
  num_node_t num_node_i, num_node_o;
  logic [COL_W-1:0] wgt_col_i;
  wgt_t wgt_data_i;
  logic row_rdy_o, wh_vld_o, src_flag_o;
  wh_row_t wh_row_o;

  // Reference model
  logic [DATA_W-1:0] w_model [FEAT_OUT][FEAT_IN];
  wh_row_t   exp_row  [MAX_ROWS];
  num_node_t exp_node [MAX_ROWS];
  logic      exp_flag [MAX_ROWS];
  int wr_ptr = 0;
  int rd_ptr = 0;
  int vld_cnt = 0;
  int err_cnt = 0;
  int test_pass = 0;
  int test_fail = 0;
  logic stream_started = 1'b0;
  logic [31:0] lcg_state = 32'h2c2b7c4d;

  spmm_core dut0 (
    .clk (clk), .rst_n (rst_n),
    .spmm_vld_i (spmm_vld_i), .pe_vld_i (pe_vld_i), .col_idx_i (col_idx_i),
    .row_len_i (row_len_i), .num_node_i (num_node_i), .src_flag_i (src_flag_i),
    .wgt_we_i (wgt_we_i), .wgt_col_i (wgt_col_i), .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i), .row_rdy_o (row_rdy_o), .wh_vld_o (wh_vld_o),
    .wh_row_o (wh_row_o), .num_node_o (num_node_o), .src_flag_o (src_flag_o)
  );

  always #2 clk = ~clk;

  // Each output strobe retires the oldest expected row
  always @(posedge clk) begin
    if (rst_n && wh_vld_o) begin
      rd_ptr <= rd_ptr + 1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && wh_vld_o) begin
      vld_cnt <= vld_cnt + 1;
    end
  end

  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (!rst_n)
    !stream_started |-> (!wh_vld_o && row_rdy_o)
  ) else begin
    $display("Mismatch at %0t ns: wh_vld_o=%b row_rdy_o=%b before the first entry",
             $time, $sampled(wh_vld_o), $sampled(row_rdy_o));
    err_cnt++;
  end

  a_row_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    wh_vld_o |-> (rd_ptr != wr_ptr)
  ) else begin
    $display("Output row arrived at %0t ns while no row was outstanding", $time);
    err_cnt++;
  end

  a_row_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    wh_vld_o |-> (wh_row_o === exp_row[rd_ptr])
  ) else begin
    $display("Mismatch at %0t ns: row %0d got %h expected %h", $time, $sampled(rd_ptr),
             $sampled(wh_row_o), exp_row[$sampled(rd_ptr)]);
    err_cnt++;
  end

  a_node_info: assert property (
    @(posedge clk) disable iff (!rst_n)
    wh_vld_o |-> (num_node_o === exp_node[rd_ptr] && src_flag_o === exp_flag[rd_ptr])
  ) else begin
    $display("Mismatch at %0t ns: row %0d node info got %0d/%b expected %0d/%b", $time,
             $sampled(rd_ptr), $sampled(num_node_o), $sampled(src_flag_o),
             exp_node[$sampled(rd_ptr)], exp_flag[$sampled(rd_ptr)]);
    err_cnt++;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Low LCG bits are weak, so use the upper ones
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8] % n);
  endfunction

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  // Large weights push banks in the lower half up and the upper half down
  task automatic load_weights(input logic extreme);
    int pick;
    for (int j = 0; j < FEAT_OUT; j++) begin
      for (int a = 0; a < FEAT_IN; a++) begin
        pick = rand_below(4);
        if (!extreme) begin
          w_model[j][a] = DATA_W'(next_rand() >> 12);
        end else if (j < FEAT_OUT / 2) begin
          w_model[j][a] = DATA_W'(pick == 0 ? 127 : pick == 1 ? 126 : pick == 2 ? 120 : 100);
        end else begin
          w_model[j][a] = DATA_W'(pick == 0 ? -128 : pick == 1 ? -127 : pick == 2 ? -120 : -100);
        end
        wgt_we_i   = 1'b1;
        wgt_col_i  = COL_W'(j);
        wgt_addr_i = col_idx_t'(a);
        wgt_data_i = w_model[j][a];
        step();
      end
    end
    wgt_we_i = 1'b0;
  endtask

  // Odd stride keeps the columns of a row distinct
  task automatic send_row(input int len, input int gap_max);
    int start;
    int stride;
    int col;
    logic [WH_W-1:0] acc [FEAT_OUT];
    logic [DATA_W-1:0] w;
    num_node_t node;
    logic flag;
    start  = rand_below(FEAT_IN);
    stride = 2 * rand_below(FEAT_IN / 2) + 1;
    node   = num_node_t'(rand_below(`SPMM_MAX_NODES));
    flag   = (rand_below(2) == 1);
    for (int j = 0; j < FEAT_OUT; j++) begin
      acc[j] = '0;
    end
    for (int k = 0; k < len; k++) begin
      col = (start + k * stride) % FEAT_IN;
      for (int j = 0; j < FEAT_OUT; j++) begin
        w = w_model[j][col];
        acc[j] = acc[j] + {{(WH_W - DATA_W){w[DATA_W-1]}}, w};
      end
    end
    for (int j = 0; j < FEAT_OUT; j++) begin
      exp_row[wr_ptr][j] = acc[j];
    end
    exp_node[wr_ptr] = node;
    exp_flag[wr_ptr] = flag;
    wr_ptr++;
    stream_started = 1'b1;
    for (int k = 0; k < len; k++) begin
      spmm_vld_i = 1'b1;
      pe_vld_i   = (k == 0);
      col_idx_i  = col_idx_t'((start + k * stride) % FEAT_IN);
      row_len_i  = row_len_t'(len);
      // Later entries carry junk node info that must be ignored
      num_node_i = (k == 0) ? node : num_node_t'(rand_below(`SPMM_MAX_NODES));
      src_flag_i = (k == 0) ? flag : (rand_below(2) == 1);
      step();
      if (k < len - 1) begin
        spmm_vld_i = 1'b0;
        pe_vld_i   = 1'b0;
        repeat (rand_below(gap_max + 1)) step();
      end
    end
    spmm_vld_i = 1'b0;
    pe_vld_i   = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    int waited;
    waited = 0;
    while (rd_ptr != wr_ptr && waited < DRAIN_LIMIT) begin
      step();
      waited++;
    end
    if (rd_ptr != wr_ptr) begin
      test_fail++;
      $display("Test %s timed out with %0d rows never returned", name, wr_ptr - rd_ptr);
    end else if (err_cnt == err_before) begin
      test_pass++;
      $display("Test %s passed, %0d rows returned so far", name, rd_ptr);
    end else begin
      test_fail++;
      $display("Test %s failed with %0d errors", name, err_cnt - err_before);
    end
  endtask

  initial begin
    int err_before;
    spmm_vld_i = 1'b0;
    pe_vld_i   = 1'b0;
    col_idx_i  = '0;
    row_len_i  = row_len_t'(1);
    num_node_i = '0;
    src_flag_i = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_col_i  = '0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    rst_n      = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    err_before = err_cnt;
    load_weights(1'b0);
    repeat (8) step();
    finish_test("reset_idle", err_before);

    err_before = err_cnt;
    repeat (N_SINGLE) send_row(1, 0);
    finish_test("single_entry", err_before);

    err_before = err_cnt;
    repeat (N_B2B) send_row(2 + rand_below(MAX_LEN - 1), 0);
    finish_test("back_to_back", err_before);

    err_before = err_cnt;
    repeat (N_GAP) send_row(2 + rand_below(MAX_LEN - 1), MAX_GAP);
    finish_test("idle_gaps", err_before);

    err_before = err_cnt;
    load_weights(1'b1);
    repeat (N_WRAP) send_row(24 + rand_below(WRAP_LEN - 23), 1);
    finish_test("node_info_wrap", err_before);

    // No stray strobes after the last row
    err_before = err_cnt;
    repeat (8) step();
    a_all_rows_out: assert (vld_cnt == wr_ptr && rd_ptr == wr_ptr) else begin
      $display("Mismatch at %0t ns: %0d strobes for %0d rows sent", $time, vld_cnt, wr_ptr);
      err_cnt++;
    end
    finish_test("strobe_count", err_before);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             test_pass, test_fail, err_cnt);
    if (test_fail == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
